/* design/bitmap_playfield.sv */
`default_nettype none
`timescale 1ns/1ps

module bitmap_playfield #(
    parameter int H_VISIBLE = video_timing_pkg::DEF_H_VISIBLE,
    parameter int H_FRONT   = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC    = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK    = video_timing_pkg::DEF_H_BACK
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire video_timing_pkg::hres_t    h_count_i,
    input  wire logic                       v_visible_i,
    input  wire logic                       end_of_line_i,
    input  wire logic                       end_of_frame_i,
    input  wire xr_regs_pkg::color_t        border_color_i,
    input  wire xr_regs_pkg::color_t        colorbase_i,
    input  wire logic                       blank_i,
    input  wire xr_regs_pkg::addr_t         start_addr_i,
    input  wire xr_regs_pkg::word_t         line_len_i,
    input  wire xr_regs_pkg::word_t         vram_data_i,
    output logic                            vram_sel_o,
    output xr_regs_pkg::addr_t              vram_addr_o,
    output xr_regs_pkg::color_t             color_index_o
);
    import video_timing_pkg::*;
    import xr_regs_pkg::*;

    localparam int H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int LEAD_START = H_TOTAL - MEM_LEAD;     // window opens in the line before

    addr_t      line_addr;          // first word of the current visible line
    addr_t      next_line_addr;
    addr_t      fetch_addr;
    hres_t      fetch_pos;          // cycles since the fetch window opened
    logic       in_lead;
    logic       lead_start;
    logic       rd_pending;         // vram_data_i valid this cycle
    word_t      q_head;
    word_t      q_tail;
    logic [1:0] q_count;
    logic       q_push;
    logic       q_pop;
    logic       pix_active;
    color_t     pix_byte;

    assign in_lead    = (h_count_i >= hres_t'(LEAD_START));
    assign lead_start = (h_count_i == hres_t'(LEAD_START));
    assign fetch_pos  = in_lead ? h_count_i - hres_t'(LEAD_START)
                                : h_count_i + hres_t'(MEM_LEAD);

    // a lead-in runs on every line, since the line before line 0 is never visible
    assign next_line_addr = v_visible_i ? line_addr + line_len_i : start_addr_i;

    // one word every other cycle, H_VISIBLE/2 words per line
    assign vram_sel_o  = !blank_i && (in_lead || v_visible_i) &&
                         (fetch_pos < hres_t'(H_VISIBLE)) && !fetch_pos[0];
    assign vram_addr_o = lead_start ? next_line_addr : fetch_addr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr   <= '0;
            fetch_addr  <= '0;
        end else begin
            if (vram_sel_o) begin
                fetch_addr <= vram_addr_o + 1'b1;
            end
            if (end_of_frame_i) begin
                line_addr <= start_addr_i;
            end else if (end_of_line_i && v_visible_i) begin
                line_addr <= line_addr + line_len_i;
            end
        end
    end

    // pixel queue, two words deep to cover the lead-in
    assign pix_active = v_visible_i && (h_count_i < hres_t'(H_VISIBLE)) && !blank_i;
    assign q_push     = rd_pending;
    assign q_pop      = pix_active && h_count_i[0] && (q_count != 2'd0);   // after low byte

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pending  <= 1'b0;
            q_count     <= 2'd0;
        end else begin
            rd_pending  <= vram_sel_o;
            if (lead_start) begin
                q_count <= 2'd0;                    // drop words from an unshown line
            end else begin
                q_count <= q_count + {1'b0, q_push} - {1'b0, q_pop};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            q_head <= (q_push && q_count == 2'd1) ? vram_data_i : q_tail;
            if (q_push) begin
                q_tail <= vram_data_i;
            end
        end else if (q_push) begin
            if (q_count == 2'd0) begin
                q_head <= vram_data_i;
            end else begin
                q_tail <= vram_data_i;
            end
        end
    end

    assign pix_byte = h_count_i[0] ? q_head[7:0] : q_head[15:8];     // high byte first

    // registered to line up with dv_de
    always_ff @(posedge clk) begin
        color_index_o <= pix_active ? (pix_byte ^ colorbase_i) : border_color_i;
    end

endmodule

`default_nettype wire

/* design/vid_config_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module vid_config_regs #(
    parameter int H_VISIBLE = video_timing_pkg::DEF_H_VISIBLE,
    parameter int V_VISIBLE = video_timing_pkg::DEF_V_VISIBLE
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_en_i,
    input  wire logic [4:0]                 reg_num_i,
    input  wire xr_regs_pkg::word_t         reg_data_i,
    input  wire video_timing_pkg::vres_t    v_count_i,
    input  wire logic                       v_visible_i,
    input  wire logic                       end_of_visible_i,
    output xr_regs_pkg::word_t              reg_data_o,
    output logic [3:0]                      intr_signal_o,
    output xr_regs_pkg::color_t             border_color_o,
    output xr_regs_pkg::color_t             pa_colorbase_o,
    output logic                            pa_blank_o,
    output xr_regs_pkg::addr_t              pa_start_addr_o,
    output xr_regs_pkg::word_t              pa_line_len_o
);
    import xr_regs_pkg::*;

    word_t rd_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o   <= 4'b0;
            border_color_o  <= BORDER_RESET;
            pa_colorbase_o  <= 8'h00;
            pa_blank_o      <= 1'b1;                    // playfield off until set up
            pa_start_addr_o <= 16'h0000;
            pa_line_len_o   <= word_t'(H_VISIBLE / 2);  // two pixels per word
        end else begin
            intr_signal_o   <= 4'b0;                    // strobes last one cycle

            if (reg_wr_en_i) begin
                case (xr_reg_e'(reg_num_i))
                    XR_VID_CTRL: begin
                        border_color_o  <= reg_data_i[15:8];
                        intr_signal_o   <= reg_data_i[3:0];
                    end
                    XR_PA_GFX_CTRL: begin
                        pa_colorbase_o  <= reg_data_i[15:8];
                        pa_blank_o      <= reg_data_i[7];
                    end
                    XR_PA_DISP_ADDR: begin
                        pa_start_addr_o <= reg_data_i;
                    end
                    XR_PA_LINE_LEN: begin
                        pa_line_len_o   <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end

            if (end_of_visible_i) begin
                intr_signal_o[3] <= 1'b1;               // vertical blank interrupt
            end
        end
    end

    // readback mux, unused numbers read zero
    always_comb begin
        case (xr_reg_e'(reg_num_i))
            XR_VID_CTRL:     rd_data = {border_color_o, 8'h00};
            XR_SCANLINE:     rd_data = {~v_visible_i, 15'(v_count_i)};
            XR_VID_HSIZE:    rd_data = word_t'(H_VISIBLE);
            XR_VID_VSIZE:    rd_data = word_t'(V_VISIBLE);
            XR_PA_GFX_CTRL:  rd_data = {pa_colorbase_o, pa_blank_o, 7'b0};
            XR_PA_DISP_ADDR: rd_data = pa_start_addr_o;
            XR_PA_LINE_LEN:  rd_data = pa_line_len_o;
            default:         rd_data = 16'h0000;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_data;
    end

endmodule

`default_nettype wire

/* design/video_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE = video_timing_pkg::DEF_H_VISIBLE,
    parameter int H_FRONT   = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC    = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK    = video_timing_pkg::DEF_H_BACK,
    parameter int V_VISIBLE = video_timing_pkg::DEF_V_VISIBLE,
    parameter int V_FRONT   = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC    = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK    = video_timing_pkg::DEF_V_BACK
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_en_i,    // one-cycle write strobe
    input  wire logic [4:0]             reg_num_i,
    input  wire xr_regs_pkg::word_t     reg_data_i,
    output wire xr_regs_pkg::word_t     reg_data_o,
    output wire logic [3:0]             intr_signal_o,
    output wire logic                   vram_sel_o,
    output wire xr_regs_pkg::addr_t     vram_addr_o,
    input  wire xr_regs_pkg::word_t     vram_data_i,    // returns the cycle after select
    output wire xr_regs_pkg::color_t    color_index_o,
    output wire logic                   hsync_o,
    output wire logic                   vsync_o,
    output wire logic                   dv_de_o
);
    import video_timing_pkg::*;
    import xr_regs_pkg::*;

    hres_t  h_count;
    vres_t  v_count;
    logic   v_visible;
    logic   end_of_line;
    logic   end_of_frame;
    logic   end_of_visible;

    color_t border_color;
    color_t pa_colorbase;
    logic   pa_blank;
    addr_t  pa_start_addr;
    word_t  pa_line_len;

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count), .v_visible_o(v_visible),
        .end_of_line_o(end_of_line), .end_of_frame_o(end_of_frame),
        .end_of_visible_o(end_of_visible),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    vid_config_regs #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)
    ) u_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .v_count_i(v_count), .v_visible_i(v_visible), .end_of_visible_i(end_of_visible),
        .reg_data_o(reg_data_o), .intr_signal_o(intr_signal_o),
        .border_color_o(border_color), .pa_colorbase_o(pa_colorbase),
        .pa_blank_o(pa_blank), .pa_start_addr_o(pa_start_addr),
        .pa_line_len_o(pa_line_len)
    );

    bitmap_playfield #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK)
    ) u_pf_a (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .v_visible_i(v_visible),
        .end_of_line_i(end_of_line), .end_of_frame_i(end_of_frame),
        .border_color_i(border_color), .colorbase_i(pa_colorbase), .blank_i(pa_blank),
        .start_addr_i(pa_start_addr), .line_len_i(pa_line_len),
        .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .color_index_o(color_index_o)
    );

endmodule

`default_nettype wire

/* design/video_timing.sv */
`default_nettype none
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE = video_timing_pkg::DEF_H_VISIBLE,
    parameter int H_FRONT   = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC    = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK    = video_timing_pkg::DEF_H_BACK,
    parameter int V_VISIBLE = video_timing_pkg::DEF_V_VISIBLE,
    parameter int V_FRONT   = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC    = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK    = video_timing_pkg::DEF_V_BACK
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    output video_timing_pkg::hres_t     h_count_o,
    output video_timing_pkg::vres_t     v_count_o,
    output logic                        v_visible_o,
    output logic                        end_of_line_o,
    output logic                        end_of_frame_o,
    output logic                        end_of_visible_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);
    import video_timing_pkg::*;

    localparam int H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START   = H_VISIBLE + H_FRONT;
    localparam int VS_START   = V_VISIBLE + V_FRONT;

    logic h_last;
    logic v_last;

    assign h_last           = (h_count_o == hres_t'(H_TOTAL - 1));
    assign v_last           = (v_count_o == vres_t'(V_TOTAL - 1));
    assign v_visible_o      = (v_count_o < vres_t'(V_VISIBLE));

    assign end_of_line_o    = h_last;
    assign end_of_frame_o   = h_last && v_last;
    assign end_of_visible_o = h_last && (v_count_o == vres_t'(V_VISIBLE - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o   <= '0;
            v_count_o   <= '0;
            hsync_o     <= 1'b0;
            vsync_o     <= 1'b0;
            dv_de_o     <= 1'b0;
        end else begin
            h_count_o   <= h_last ? '0 : h_count_o + 1'b1;
            if (h_last) begin
                v_count_o <= v_last ? '0 : v_count_o + 1'b1;
            end

            // outputs follow the counter by one cycle
            hsync_o     <= (h_count_o >= hres_t'(HS_START)) &&
                           (h_count_o < hres_t'(HS_START + H_SYNC));
            vsync_o     <= (v_count_o >= vres_t'(VS_START)) &&
                           (v_count_o < vres_t'(VS_START + V_SYNC));
            dv_de_o     <= (h_count_o < hres_t'(H_VISIBLE)) && v_visible_o;
        end
    end

endmodule

`default_nettype wire

/* design/video_timing_pkg.sv */
`default_nettype none

package video_timing_pkg;

    typedef logic [10:0] hres_t;            // horizontal counter, one word
    typedef logic [9:0]  vres_t;            // vertical counter

    // 640x480 defaults at the usual 25.175 MHz pixel clock
    localparam int DEF_H_VISIBLE = 640;
    localparam int DEF_H_FRONT   = 16;
    localparam int DEF_H_SYNC    = 96;
    localparam int DEF_H_BACK    = 48;

    localparam int DEF_V_VISIBLE = 480;
    localparam int DEF_V_FRONT   = 10;
    localparam int DEF_V_SYNC    = 2;
    localparam int DEF_V_BACK    = 33;

    // playfield starts reading this many cycles before the first pixel
    localparam int MEM_LEAD      = 4;

endpackage

`default_nettype wire

/* design/xr_regs_pkg.sv */
`default_nettype none

package xr_regs_pkg;

    typedef logic [15:0] word_t;            // register and vram data word
    typedef logic [15:0] addr_t;            // vram word address
    typedef logic [7:0]  color_t;           // palette index

    // register numbers, 16 and up belong to the playfield
    typedef enum logic [4:0] {
        XR_VID_CTRL     = 5'h00,            // border colour, interrupt strobes
        XR_SCANLINE     = 5'h02,            // read only
        XR_VID_HSIZE    = 5'h08,            // read only
        XR_VID_VSIZE    = 5'h09,            // read only
        XR_PA_GFX_CTRL  = 5'h10,            // colourbase, blank
        XR_PA_DISP_ADDR = 5'h12,
        XR_PA_LINE_LEN  = 5'h13
    } xr_reg_e;

    localparam color_t BORDER_RESET = 8'h08;    // dark grey, shows the core is alive

endpackage

`default_nettype wire

/* project.f */
+incdir+include
design/video_timing_pkg.sv
design/xr_regs_pkg.sv
design/video_timing.sv
design/vid_config_regs.sv
design/bitmap_playfield.sv
design/video_gen.sv
test/tb_video_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the video_gen testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_video_gen \
    -o tb_video_gen

./obj_dir/tb_video_gen | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

/* include/tb_video_gen_tests.svh */
`ifndef TB_VIDEO_GEN_TESTS_SVH
`define TB_VIDEO_GEN_TESTS_SVH

task automatic tick();
    @(posedge clk);
    #1;                                     // drive and sample away from the edge
endtask

task automatic check(input bit ok, input string what);
    check_count++;
    assert (ok) else begin
        $display("error at %0t ns: %s", $time, what);
        error_count++;
    end
endtask

task automatic report_test(input int num, input string name, input int start_errors);
    $display("test %0d (%s) finished with %0d errors", num, name, error_count - start_errors);
endtask

task automatic write_reg(input logic [4:0] num, input word_t data);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    tick();
    reg_wr_en_i = 1'b0;
endtask

task automatic expect_reg(input logic [4:0] num, input word_t exp, input string name);
    reg_num_i = num;
    tick();                                 // readback is one cycle behind the number
    check(reg_data_o == exp, $sformatf("%s reads %h, expected %h", name, reg_data_o, exp));
endtask

// leaves us just after vsync, so the next enabled pixel is line 0
task automatic sync_to_frame();
    while (!vsync_o) tick();
    while (vsync_o) tick();
endtask

function automatic color_t expected_pixel(input int x, input int y, input color_t base);
    word_t w;
    w = vram_mem[(PA_START + y * PA_LEN + x / 2) % 256];
    return ((x % 2 == 0) ? w[15:8] : w[7:0]) ^ base;
endfunction

task automatic check_frame_pixels(input bit show_border, input color_t value);
    int     pixel;
    int     i;
    color_t exp;
    pixel = 0;
    for (i = 0; i < FRAME_LEN; i++) begin
        if (dv_de_o) begin
            exp = show_border ? value
                              : expected_pixel(pixel % H_VISIBLE, pixel / H_VISIBLE, value);
            check(color_index_o == exp, $sformatf("pixel x %0d y %0d is %h, expected %h",
                  pixel % H_VISIBLE, pixel / H_VISIBLE, color_index_o, exp));
            pixel++;
        end
        tick();
    end
    check(pixel == H_VISIBLE * V_VISIBLE,
          $sformatf("frame showed %0d pixels instead of %0d", pixel, H_VISIBLE * V_VISIBLE));
endtask

task automatic run_length(input int len, input int exp, input string name);
    check(len == exp, $sformatf("%s stayed high for %0d cycles instead of %0d", name, len, exp));
endtask

task automatic reset_border_test();
    int start_errors;
    int i;
    start_errors = error_count;
    for (i = 0; i < FRAME_LEN; i++) begin
        check(intr_signal_o[2:0] == 3'b000,
              $sformatf("strobe bits %b set without a write", intr_signal_o[2:0]));
        check(!vram_sel_o, "vram read issued while the playfield is blanked");
        if (dv_de_o) begin
            check(color_index_o == 8'h08,
                  $sformatf("pixel %h, expected reset border 08", color_index_o));
        end
        tick();
    end
    expect_reg(XR_VID_HSIZE, 16'(H_VISIBLE), "hsize");
    expect_reg(XR_VID_VSIZE, 16'(V_VISIBLE), "vsize");
    report_test(1, "reset state and border", start_errors);
endtask

task automatic bitmap_pixel_test();
    int start_errors;
    start_errors = error_count;
    write_reg(XR_PA_DISP_ADDR, 16'(PA_START));
    write_reg(XR_PA_LINE_LEN, 16'(PA_LEN));
    write_reg(XR_PA_GFX_CTRL, 16'h0000);    // colourbase 0, blank off
    sync_to_frame();
    check_frame_pixels(1'b0, 8'h00);
    report_test(2, "bitmap pixels", start_errors);
endtask

task automatic colorbase_blank_test();
    int start_errors;
    start_errors = error_count;
    write_reg(XR_PA_GFX_CTRL, {COLORBASE, 8'h00});
    sync_to_frame();
    check_frame_pixels(1'b0, COLORBASE);
    write_reg(XR_VID_CTRL, {NEW_BORDER, 8'h00});
    write_reg(XR_PA_GFX_CTRL, {COLORBASE, 8'h80});
    sync_to_frame();
    check_frame_pixels(1'b1, NEW_BORDER);   // blanked, border only
    report_test(3, "colourbase and blank", start_errors);
endtask

task automatic readback_test();
    int start_errors;
    start_errors = error_count;
    expect_reg(XR_VID_CTRL, {NEW_BORDER, 8'h00}, "video control");
    expect_reg(XR_PA_GFX_CTRL, {COLORBASE, 1'b1, 7'b0}, "playfield control");
    expect_reg(XR_PA_DISP_ADDR, 16'(PA_START), "display address");
    expect_reg(XR_PA_LINE_LEN, 16'(PA_LEN), "line length");
    expect_reg(5'h05, 16'h0000, "unused register 05");
    expect_reg(5'h1f, 16'h0000, "unused register 1f");
    report_test(4, "register readback", start_errors);
endtask

task automatic timing_count_test();
    int   start_errors;
    int   i;
    int   de_run, hs_run, vs_run;
    int   de_runs, hs_runs, vs_runs;
    int   line;
    int   flagged;
    logic de, hs, vs;
    start_errors = error_count;
    de_run  = 0;
    hs_run  = 0;
    vs_run  = 0;
    de_runs = 0;
    hs_runs = 0;
    vs_runs = 0;
    sync_to_frame();
    for (i = 0; i <= FRAME_LEN; i++) begin
        de = (i < FRAME_LEN) && dv_de_o;    // last pass closes any open run
        hs = (i < FRAME_LEN) && hsync_o;
        vs = (i < FRAME_LEN) && vsync_o;
        if (de) de_run++;
        else if (de_run != 0) begin
            run_length(de_run, H_VISIBLE, "dv_de");
            de_runs++;
            de_run = 0;
        end
        if (hs) hs_run++;
        else if (hs_run != 0) begin
            run_length(hs_run, H_SYNC, "hsync");
            hs_runs++;
            hs_run = 0;
        end
        if (vs) vs_run++;
        else if (vs_run != 0) begin
            run_length(vs_run, V_SYNC * H_TOTAL, "vsync");
            vs_runs++;
            vs_run = 0;
        end
        tick();
    end
    check(de_runs == V_VISIBLE, $sformatf("dv_de active on %0d lines, not %0d", de_runs, V_VISIBLE));
    check(hs_runs == V_TOTAL, $sformatf("%0d hsync pulses in a frame, not %0d", hs_runs, V_TOTAL));
    check(vs_runs == 1, $sformatf("%0d vsync pulses in a frame, not 1", vs_runs));

    reg_num_i = XR_SCANLINE;
    tick();
    flagged = 0;
    for (i = 0; i < FRAME_LEN; i++) begin
        line = int'(reg_data_o[9:0]);
        check(reg_data_o[15] == (line >= V_VISIBLE),
              $sformatf("scanline %0d has blank flag %b", line, reg_data_o[15]));
        if (reg_data_o[15]) flagged++;
        tick();
    end
    check(flagged == (V_TOTAL - V_VISIBLE) * H_TOTAL,
          $sformatf("blank flag set for %0d cycles per frame", flagged));
    report_test(5, "timing counts", start_errors);
endtask

task automatic interrupt_test();
    int         start_errors;
    int         i;
    int         strobes;
    int         vblanks;
    logic [3:0] prev;
    start_errors = error_count;
    strobes = 0;
    vblanks = 0;
    prev    = 4'b0000;
    sync_to_frame();                        // far from the end of the visible area
    write_reg(XR_VID_CTRL, {NEW_BORDER, 8'h05});
    for (i = 0; i < 2 * FRAME_LEN; i++) begin
        if (intr_signal_o != 4'b0000) begin
            check(prev == 4'b0000, "interrupt pulse lasted longer than one cycle");
            if (intr_signal_o == 4'b0101) strobes++;
            else if (intr_signal_o == 4'b1000) vblanks++;
            else check(1'b0, $sformatf("unexpected interrupt bits %b", intr_signal_o));
        end
        prev = intr_signal_o;
        tick();
    end
    check(strobes == 1, $sformatf("saw %0d write strobe pulses instead of 1", strobes));
    check(vblanks == 2, $sformatf("saw %0d frame pulses in two frames", vblanks));
    report_test(6, "interrupts", start_errors);
endtask

`endif

/* test/tb_video_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_video_gen;
    import xr_regs_pkg::*;

    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 2;
    localparam int H_BACK    = 4;
    localparam int V_VISIBLE = 4;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 1;
    localparam int V_BACK    = 1;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;

    // frames per test with syncs, summed 1 + 3 + 6 + 1 + 5 + 4
    localparam int TEST_FRAMES    = 20;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_LEN + 200;

    localparam int     PA_START   = 32;
    localparam int     PA_LEN     = 10;         // words per line, wider than the visible line
    localparam color_t COLORBASE  = 8'h5a;
    localparam color_t NEW_BORDER = 8'hc3;

    logic       clk;
    logic       reset_i;
    logic       reg_wr_en_i;
    logic [4:0] reg_num_i;
    word_t      reg_data_i;
    word_t      reg_data_o;
    logic [3:0] intr_signal_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    word_t      vram_data_i = 16'h0000;
    color_t     color_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    word_t      vram_mem [256];
    integer     seed;
    integer     rnd;
    int         fill_idx;
    logic       mem_sel;
    logic [7:0] mem_addr;
    int         error_count;
    int         check_count;
    int         cycle_count;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) UUT (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_en_i(reg_wr_en_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .reg_data_o(reg_data_o), .intr_signal_o(intr_signal_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .color_index_o(color_index_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        seed = 32'h1c808610;
        for (fill_idx = 0; fill_idx < 256; fill_idx++) begin
            rnd                = $random(seed);
            vram_mem[fill_idx] = rnd[15:0];
        end
    end

    // vram answers on the cycle after the select
    always @(posedge clk) begin
        mem_sel  <= vram_sel_o;
        mem_addr <= vram_addr_o[7:0];     // 256 words, upper address bits ignored
        #1;
        if (mem_sel) begin
            vram_data_i = vram_mem[mem_addr];
        end
    end

    `include "tb_video_gen_tests.svh"

    initial begin
        reg_wr_en_i = 1'b0;
        reg_num_i   = 5'h00;
        reg_data_i  = 16'h0000;
        reset_i     = 1'b1;
        error_count = 0;
        check_count = 0;
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;

        reset_border_test();
        bitmap_pixel_test();
        colorbase_blank_test();
        readback_test();
        timing_count_test();
        interrupt_test();

        $display("summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
